// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_banked_mem
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF -- '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sources.f
src/banked_mem_pkg.sv
src/mem_req_decode.sv
src/write_buffer.sv
src/bank_array.sv
src/banked_mem_top.sv
verification/tb_banked_mem_checks.sv
verification/tb_banked_mem.sv

// File: src/bank_array.sv
`timescale 1ns/1ps

module bank_array (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                rd_strobe,
   input  logic [banked_mem_pkg::bank_bits-1:0] req_bank,
   input  logic [banked_mem_pkg::row_bits-1:0]  req_row,
   input  logic                                bank_we,
   input  logic [banked_mem_pkg::bank_bits-1:0] bank_wr_bank,
   input  logic [banked_mem_pkg::row_bits-1:0]  bank_wr_row,
   input  logic [banked_mem_pkg::data_w-1:0]    bank_wr_data,
   input  logic                                fwd_hit,
   input  logic [banked_mem_pkg::data_w-1:0]    fwd_data,
   output logic                                rdata_valid,
   output logic [banked_mem_pkg::data_w-1:0]    rdata,
   output logic                                wr_complete
);

   localparam int nb = banked_mem_pkg::bank_cnt;

   logic [nb-1:0]                          rd_sel;     // one-hot read bank
   logic [nb-1:0]                          wr_sel;     // one-hot write bank
   logic [banked_mem_pkg::data_w-1:0]      bank_dout [nb];
   logic [banked_mem_pkg::bank_bits-1:0]   rd_bank_q;  // bank of the read in flight
   logic                                   rd_valid_q;

   assign rd_sel = rd_strobe ? ({{(nb-1){1'b0}}, 1'b1} << req_bank) : '0;
   assign wr_sel = bank_we ? ({{(nb-1){1'b0}}, 1'b1} << bank_wr_bank) : '0;

   // read and drain never share a bank, so each bank sees one access per cycle
   for (genvar b = 0; b < nb; b++) begin : g_bank
      logic [banked_mem_pkg::data_w-1:0] mem [banked_mem_pkg::row_cnt];
      logic [banked_mem_pkg::data_w-1:0] q;   // registered read word

      always_ff @(posedge clk) begin
         if (wr_sel[b]) begin
            mem[bank_wr_row] <= bank_wr_data;
         end
         if (rd_sel[b]) begin
            q <= mem[req_row];
         end
      end

      assign bank_dout[b] = q;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid_q  <= 1'b0;
         wr_complete <= 1'b0;
      end else begin
         rd_valid_q  <= rd_strobe;
         wr_complete <= bank_we;  // one pulse per committed write
      end
   end

   always_ff @(posedge clk) begin
      if (rd_strobe) begin
         rd_bank_q <= req_bank;
      end
   end

   // buffered data is newer than the bank contents
   assign rdata_valid = rd_valid_q;
   assign rdata       = fwd_hit ? fwd_data : bank_dout[rd_bank_q];

endmodule

// File: src/banked_mem_pkg.sv
package banked_mem_pkg;

   // data path
   localparam int data_w = 32;

   // bank geometry
   localparam int bank_cnt  = 16;
   localparam int bank_bits = 4;     // log2(bank_cnt)
   localparam int row_cnt   = 1024;  // words per bank
   localparam int row_bits  = 10;    // log2(row_cnt)
   localparam int addr_bits = row_bits + bank_bits;  // 14-bit word address

   // posted-write buffer
   localparam int wbuf_depth    = 4;
   localparam int wbuf_ptr_bits = 2;  // log2(wbuf_depth)

   // one address word, seen either flat or as bank/row
   // bank sits in the low bits so consecutive words interleave over the banks
   typedef union packed {
      logic [addr_bits-1:0] word_addr;  // flat word address
      struct packed {
         logic [row_bits-1:0]  row;   // word inside the bank
         logic [bank_bits-1:0] bank;  // bank select
      } split;
   } mem_addr_u;

endpackage

// File: src/banked_mem_top.sv
`timescale 1ns/1ps

module banked_mem_top (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req,
   input  logic                                we,
   input  logic [banked_mem_pkg::addr_bits-1:0] addr,
   input  logic [banked_mem_pkg::data_w-1:0]    wdata,
   output logic                                rdata_valid,
   output logic [banked_mem_pkg::data_w-1:0]    rdata,
   output logic                                wr_complete,
   output logic                                busy
);

   // decoded request
   logic                                rd_strobe;
   logic                                wr_strobe;
   logic [banked_mem_pkg::bank_bits-1:0] req_bank;
   logic [banked_mem_pkg::row_bits-1:0]  req_row;
   logic [banked_mem_pkg::data_w-1:0]    req_wdata;

   // drain port
   logic                                bank_we;
   logic [banked_mem_pkg::bank_bits-1:0] bank_wr_bank;
   logic [banked_mem_pkg::row_bits-1:0]  bank_wr_row;
   logic [banked_mem_pkg::data_w-1:0]    bank_wr_data;

   // forwarding result
   logic                                fwd_hit;
   logic [banked_mem_pkg::data_w-1:0]    fwd_data;

   mem_req_decode i_decode (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .we        (we),
      .addr      (addr),
      .wdata     (wdata),
      .rd_strobe (rd_strobe),
      .wr_strobe (wr_strobe),
      .req_bank  (req_bank),
      .req_row   (req_row),
      .req_wdata (req_wdata)
   );

   write_buffer i_wbuf (
      .clk          (clk),
      .reset        (reset),
      .rd_strobe    (rd_strobe),
      .wr_strobe    (wr_strobe),
      .req_bank     (req_bank),
      .req_row      (req_row),
      .req_wdata    (req_wdata),
      .bank_we      (bank_we),
      .bank_wr_bank (bank_wr_bank),
      .bank_wr_row  (bank_wr_row),
      .bank_wr_data (bank_wr_data),
      .fwd_hit      (fwd_hit),
      .fwd_data     (fwd_data),
      .busy         (busy)
   );

   bank_array i_banks (
      .clk          (clk),
      .reset        (reset),
      .rd_strobe    (rd_strobe),
      .req_bank     (req_bank),
      .req_row      (req_row),
      .bank_we      (bank_we),
      .bank_wr_bank (bank_wr_bank),
      .bank_wr_row  (bank_wr_row),
      .bank_wr_data (bank_wr_data),
      .fwd_hit      (fwd_hit),
      .fwd_data     (fwd_data),
      .rdata_valid  (rdata_valid),
      .rdata        (rdata),
      .wr_complete  (wr_complete)
   );

endmodule

// File: src/mem_req_decode.sv
`timescale 1ns/1ps

module mem_req_decode (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req,        // request strobe
   input  logic                                we,         // 1 = write, 0 = read
   input  logic [banked_mem_pkg::addr_bits-1:0] addr,
   input  logic [banked_mem_pkg::data_w-1:0]    wdata,
   output logic                                rd_strobe,
   output logic                                wr_strobe,
   output logic [banked_mem_pkg::bank_bits-1:0] req_bank,
   output logic [banked_mem_pkg::row_bits-1:0]  req_row,
   output logic [banked_mem_pkg::data_w-1:0]    req_wdata
);

   banked_mem_pkg::mem_addr_u in_addr;  // incoming address, split view

   assign in_addr.word_addr = addr;

   // request strobes
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_strobe <= 1'b0;
         wr_strobe <= 1'b0;
      end else begin
         rd_strobe <= req & ~we;
         wr_strobe <= req & we;
      end
   end

   // bank, row and data of the request
   always_ff @(posedge clk) begin
      if (req) begin
         req_bank  <= in_addr.split.bank;  // low bits pick the bank
         req_row   <= in_addr.split.row;
         req_wdata <= wdata;
      end
   end

endmodule

// File: src/write_buffer.sv
`timescale 1ns/1ps

module write_buffer (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                rd_strobe,
   input  logic                                wr_strobe,
   input  logic [banked_mem_pkg::bank_bits-1:0] req_bank,
   input  logic [banked_mem_pkg::row_bits-1:0]  req_row,
   input  logic [banked_mem_pkg::data_w-1:0]    req_wdata,
   output logic                                bank_we,       // drain head into its bank
   output logic [banked_mem_pkg::bank_bits-1:0] bank_wr_bank,
   output logic [banked_mem_pkg::row_bits-1:0]  bank_wr_row,
   output logic [banked_mem_pkg::data_w-1:0]    bank_wr_data,
   output logic                                fwd_hit,       // aligned with bank read data
   output logic [banked_mem_pkg::data_w-1:0]    fwd_data,
   output logic                                busy
);

   localparam int ptr_w = banked_mem_pkg::wbuf_ptr_bits;
   localparam int cnt_w = banked_mem_pkg::wbuf_ptr_bits + 1;

   // entry storage
   banked_mem_pkg::mem_addr_u             ent_addr [banked_mem_pkg::wbuf_depth];
   logic [banked_mem_pkg::data_w-1:0]     ent_data [banked_mem_pkg::wbuf_depth];

   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;   // 0 .. wbuf_depth
   logic             empty;
   logic             full;
   logic             push;
   logic             pop;
   logic             head_conflict;

   banked_mem_pkg::mem_addr_u          push_addr;  // write address, built from bank/row
   banked_mem_pkg::mem_addr_u          rd_addr;    // read address for the search
   logic                               hit;
   logic [banked_mem_pkg::data_w-1:0]  hit_data;
   logic [ptr_w-1:0]                   off;
   logic [ptr_w-1:0]                   idx;

   assign empty = (count == '0);
   assign full  = (count == cnt_w'(banked_mem_pkg::wbuf_depth));
   assign busy  = full;

   assign push_addr.split.bank = req_bank;
   assign push_addr.split.row  = req_row;
   assign rd_addr.split.bank   = req_bank;
   assign rd_addr.split.row    = req_row;

   // head of the FIFO goes to the banks
   assign bank_wr_bank = ent_addr[rd_ptr].split.bank;
   assign bank_wr_row  = ent_addr[rd_ptr].split.row;
   assign bank_wr_data = ent_data[rd_ptr];

   // a read always wins its bank
   assign head_conflict = rd_strobe && (req_bank == ent_addr[rd_ptr].split.bank);
   assign bank_we       = !empty && !head_conflict;
   assign pop           = bank_we;
   assign push          = wr_strobe && (!full || pop);  // full write is off contract

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         ent_addr[wr_ptr] <= push_addr;
         ent_data[wr_ptr] <= req_wdata;
      end
   end

   // Forwarding search. Walk from the head towards the tail, so a later
   // match overrides an earlier one and the newest buffered write wins.
   // The head that drains this cycle is still part of the walk.
   always_comb begin
      hit      = 1'b0;
      hit_data = ent_data[rd_ptr];
      off      = '0;
      idx      = rd_ptr;
      for (int k = 0; k < banked_mem_pkg::wbuf_depth; k++) begin
         off = k[ptr_w-1:0];
         idx = rd_ptr + off;
         if (({1'b0, off} < count) && (ent_addr[idx].word_addr == rd_addr.word_addr)) begin
            hit      = 1'b1;
            hit_data = ent_data[idx];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_hit <= 1'b0;
      end else begin
         fwd_hit <= rd_strobe && hit;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_strobe) begin
         fwd_data <= hit_data;  // only used when fwd_hit
      end
   end

endmodule

// File: verification/tb_banked_mem.sv
`timescale 1ns/1ps

module tb_banked_mem;

   localparam int clk_period      = 4;
   localparam int reset_cycles    = 5;
   localparam int quiet_cycles    = 8;
   localparam int set_size        = 32;   // addresses used by the tests
   localparam int fwd_rounds      = 8;
   localparam int conflict_rounds = 16;
   localparam int mixed_cycles    = 400;
   localparam int drain_limit     = 20;
   localparam int stim_cycles     = reset_cycles + quiet_cycles + 2 * set_size + 24
                                    + 6 * fwd_rounds + 4 * conflict_rounds
                                    + mixed_cycles + 4 + drain_limit;

   logic                                 clk;
   logic                                 reset;
   logic                                 req;
   logic                                 we;
   logic [banked_mem_pkg::addr_bits-1:0] addr;
   logic [banked_mem_pkg::data_w-1:0]    wdata;
   logic                                 rdata_valid;
   logic [banked_mem_pkg::data_w-1:0]    rdata;
   logic                                 wr_complete;
   logic                                 busy;
   logic                                 failed;
   int                                   outstanding;

   logic [31:0]                          rng;
   logic [banked_mem_pkg::addr_bits-1:0] addr_set [set_size];

   banked_mem_top i_dut (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .we          (we),
      .addr        (addr),
      .wdata       (wdata),
      .rdata_valid (rdata_valid),
      .rdata       (rdata),
      .wr_complete (wr_complete),
      .busy        (busy)
   );

   tb_banked_mem_checks i_checks (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .we          (we),
      .addr        (addr),
      .wdata       (wdata),
      .rdata_valid (rdata_valid),
      .rdata       (rdata),
      .wr_complete (wr_complete),
      .busy        (busy),
      .failed      (failed),
      .outstanding (outstanding)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // bank in the low bits, row above it
   function automatic logic [banked_mem_pkg::addr_bits-1:0] make_addr(
      input logic [banked_mem_pkg::row_bits-1:0]  row,
      input logic [banked_mem_pkg::bank_bits-1:0] bank);
      return {row, bank};
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped");
   endtask

   task automatic send_idle(input int n);
      repeat (n) begin
         @(posedge clk);
         req <= 1'b0;
         we  <= 1'b0;
      end
   endtask

   task automatic read_word(input logic [banked_mem_pkg::addr_bits-1:0] a);
      @(posedge clk);
      req  <= 1'b1;
      we   <= 1'b0;
      addr <= a;
   endtask

   task automatic write_word(input logic [banked_mem_pkg::addr_bits-1:0] a,
                             input logic [banked_mem_pkg::data_w-1:0] d);
      @(posedge clk);
      if (busy) begin  // hold the write off while the buffer is full
         req <= 1'b0;
         we  <= 1'b0;
      end else begin
         req   <= 1'b1;
         we    <= 1'b1;
         addr  <= a;
         wdata <= d;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial begin
      #((stim_cycles + 200) * clk_period);
      stop_with_failure("timeout: the run did not finish in the expected time");
   end

   always @(posedge failed) begin
      stop_with_failure("a check on the DUT outputs failed");
   end

   initial begin
      logic [banked_mem_pkg::addr_bits-1:0] a;
      logic [banked_mem_pkg::addr_bits-1:0] b;
      int                                   w;
      reset = 1'b1;
      req   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      wdata = '0;
      rng   = 32'h956f;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;
      send_idle(quiet_cycles);

      for (int i = 0; i < set_size; i++) begin  // two addresses per bank
         rng = xorshift32(rng);
         addr_set[i] = make_addr(rng[25:16], i[3:0]);
      end
      for (int i = 0; i < set_size; i++) begin
         rng = xorshift32(rng);
         write_word(addr_set[i], rng);
      end
      send_idle(20);
      for (int i = 0; i < set_size; i++) begin
         read_word(addr_set[i]);
      end
      send_idle(4);

      // reads right behind writes to the same word
      for (int r = 0; r < fwd_rounds; r++) begin
         rng = xorshift32(rng);
         a = addr_set[rng[4:0]];
         write_word(a, xorshift32(rng));
         read_word(a);
         write_word(a, ~rng);
         write_word(a, rng ^ 32'h0f0f_0f0f);
         read_word(a);
         send_idle(1);
      end

      // reads aimed at the bank the buffer wants to drain
      for (int r = 0; r < conflict_rounds; r++) begin
         a = addr_set[(2 * r) % set_size];
         b = addr_set[(2 * r + 16) % set_size];
         rng = xorshift32(rng);
         write_word(a, rng);
         read_word(b);
         write_word(b, ~rng);
         read_word(a);
      end

      for (int c = 0; c < mixed_cycles; c++) begin
         rng = xorshift32(rng);
         a = addr_set[rng[4:0]];
         if (rng[10:8] == 3'd0) begin
            send_idle(1);
         end else if (rng[11]) begin
            write_word(a, xorshift32(rng));
         end else begin
            read_word(a);
         end
      end
      send_idle(4);

      // counts and checks of the last edge have settled at the falling edge
      w = 0;
      @(negedge clk);
      while (w < drain_limit && outstanding != 0) begin
         @(negedge clk);
         w++;
      end
      if (outstanding != 0) begin
         stop_with_failure("writes still outstanding after the drain window");
      end else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

// File: verification/tb_banked_mem_checks.sv
`timescale 1ns/1ps

module tb_banked_mem_checks (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 req,
   input  logic                                 we,
   input  logic [banked_mem_pkg::addr_bits-1:0] addr,
   input  logic [banked_mem_pkg::data_w-1:0]    wdata,
   input  logic                                 rdata_valid,
   input  logic [banked_mem_pkg::data_w-1:0]    rdata,
   input  logic                                 wr_complete,
   input  logic                                 busy,
   output logic                                 failed,       // set at the first failed check
   output int                                   outstanding   // writes not yet completed
);

   localparam int words = banked_mem_pkg::bank_cnt * banked_mem_pkg::row_cnt;

   logic [banked_mem_pkg::data_w-1:0] ref_mem [words];  // reference memory
   bit                                written [words];
   logic [banked_mem_pkg::data_w-1:0] exp_q [$];        // reads in flight
   int                                due_q [$];        // cycle each read is due
   int                                cycle;
   int                                open_wr;
   bit                                seen_req;

   initial begin
      failed      = 1'b0;
      outstanding = 0;
      open_wr     = 0;
      cycle       = 0;
      seen_req    = 1'b0;
   end

   always @(posedge clk) begin
      cycle++;
      if (reset) begin
         exp_q.delete();
         due_q.delete();
         open_wr  = 0;
         seen_req = 1'b0;
      end else begin
         if (!seen_req) begin  // quiet outputs before the first request
            assert (!rdata_valid && !wr_complete && !busy) else begin
               $display("[ERROR] rdata_valid wr_complete busy: expected 0x0 0x0 0x0, %s",
                        $sformatf("got 0x%0h 0x%0h 0x%0h", rdata_valid, wr_complete, busy));
               failed <= 1'b1;
            end
         end

         if (due_q.size() != 0 && due_q[0] == cycle) begin
            assert (rdata_valid) else begin
               $display("[ERROR] rdata_valid: expected 0x1, got 0x%0h", rdata_valid);
               failed <= 1'b1;
            end
            assert (rdata === exp_q[0]) else begin
               $display("[ERROR] rdata: expected 0x%08h, got 0x%08h", exp_q[0], rdata);
               failed <= 1'b1;
            end
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
         end else begin
            assert (!rdata_valid) else begin
               $display("[ERROR] rdata_valid: expected 0x0, got 0x%0h", rdata_valid);
               failed <= 1'b1;
            end
         end

         if (wr_complete) begin
            assert (open_wr > 0) else begin
               $display("[ERROR] wr_complete: expected 0x0, got 0x%0h with no write open",
                        wr_complete);
               failed <= 1'b1;
            end
            if (open_wr > 0) begin
               open_wr--;
            end
         end

         // a full buffer needs four writes still open
         assert (!busy || open_wr >= banked_mem_pkg::wbuf_depth) else begin
            $display("[ERROR] busy: expected 0x0, got 0x%0h with 0x%0h writes open",
                     busy, open_wr);
            failed <= 1'b1;
         end

         if (req) begin
            seen_req = 1'b1;
            if (we) begin
               ref_mem[addr] = wdata;  // visible to any later read through forwarding
               written[addr] = 1'b1;
               open_wr++;
            end else begin
               assert (written[addr]) else begin
                  $display("read of address 0x%04h that was never written", addr);
                  failed <= 1'b1;
               end
               exp_q.push_back(ref_mem[addr]);
               due_q.push_back(cycle + 2);
            end
         end
      end
      outstanding <= open_wr;
   end

endmodule
